//--- verilog/l2c_pkg.sv
/*
 * L2C preheat shared definitions
 * Sizes, layer types and the packed structs used on the
 * controller, FIFO, GLB and PE row paths
 */
`default_nettype none

package l2c_pkg;

    // ========================================
    // Sizes
    // ========================================
    localparam int NUM_LANES    = 4;                // PE rows
    localparam int NUM_REQ      = 2 * NUM_LANES;    // Ifmap lanes first, then ipsum lanes
    localparam int REQ_IDX_W    = $clog2(NUM_REQ);

    localparam int GLB_DEPTH    = 128;
    localparam int GLB_AW       = 7;
    localparam int GLB_DW       = 16;
    localparam int REGION_WORDS = 16;               // GLB words owned by one requester
    localparam int FETCH_W      = $clog2(REGION_WORDS) + 1;

    localparam int FIFO_DEPTH   = 8;
    localparam int FIFO_AW      = $clog2(FIFO_DEPTH);
    localparam int CNT_W        = 4;                // Pop count width

    typedef logic [GLB_AW-1:0]    glb_addr_t;
    typedef logic [GLB_DW-1:0]    glb_data_t;
    typedef logic [CNT_W-1:0]     cnt_t;
    typedef logic [REQ_IDX_W-1:0] req_idx_t;

    // ========================================
    // Layer type
    // ========================================
    typedef enum logic [1:0] {
        POINTWISE = 2'd0,
        DEPTHWISE = 2'd1,
        STANDARD  = 2'd2,
        LINEAR    = 2'd3
    } layer_type_e;

    // ========================================
    // Payloads and requests
    // ========================================
    typedef struct packed {
        logic [7:0] act;        // Low byte of a GLB word
    } ifmap_t;

    typedef struct packed {
        logic [15:0] psum;
    } ipsum_t;

    typedef struct packed {
        logic      req;
        glb_addr_t addr;
    } glb_req_t;

    typedef struct packed {
        logic need_pop;         // One-cycle strobe
        cnt_t count;
    } pop_cmd_t;

endpackage

`default_nettype wire

//--- verilog/l2c_preheat_ctrl.sv
/*
 * Preheat controller
 * Derives per-lane pop counts from the layer type, sends them to the
 * ifmap and ipsum FIFOs and waits until every FIFO reports done
 */
`timescale 1ns/100ps
`default_nettype none

module l2c_preheat_ctrl (
    input  wire logic                                           clk,
    input  wire logic                                           rst_n,
    input  wire logic                                           start_preheat_i,
    input  wire l2c_pkg::layer_type_e                           layer_type_i,
    input  wire logic [l2c_pkg::NUM_LANES-1:0]                  ifmap_done_i,
    input  wire logic [l2c_pkg::NUM_LANES-1:0]                  ipsum_done_i,
    output l2c_pkg::pop_cmd_t [l2c_pkg::NUM_LANES-1:0]          ifmap_cmd_o,
    output l2c_pkg::pop_cmd_t [l2c_pkg::NUM_LANES-1:0]          ipsum_cmd_o,
    output logic                                                opsum_push_one_o,
    output logic                                                preheat_done_o
);

    typedef enum logic [1:0] {
        IDLE,
        SET_POP_NUM,
        WAIT_DONE,
        DONE
    } state_e;

    state_e state_q, state_d;
    logic   all_done;

    // Ifmap words one PE row needs for the given layer type
    function automatic l2c_pkg::cnt_t ifmap_count(input l2c_pkg::layer_type_e lt,
                                                  input int lane);
        case (lt)
            l2c_pkg::POINTWISE: ifmap_count = l2c_pkg::cnt_t'(1);
            l2c_pkg::DEPTHWISE: ifmap_count = l2c_pkg::cnt_t'(3 * (lane / 3 + 1));
            l2c_pkg::STANDARD:  ifmap_count = l2c_pkg::cnt_t'(3);
            l2c_pkg::LINEAR:    ifmap_count = l2c_pkg::cnt_t'(1);
            default:            ifmap_count = l2c_pkg::cnt_t'(1);
        endcase
    endfunction

    assign all_done = &ifmap_done_i && &ipsum_done_i;

    // ========================================
    // State machine
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_preheat_i) begin
                    state_d = SET_POP_NUM;
                end
            end
            SET_POP_NUM: state_d = WAIT_DONE;   // FIFOs load counts on this edge
            WAIT_DONE: begin
                if (all_done) begin
                    state_d = DONE;
                end
            end
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // ========================================
    // Pop commands
    // ========================================
    always_comb begin
        for (int k = 0; k < l2c_pkg::NUM_LANES; k++) begin
            ifmap_cmd_o[k] = '0;
            ipsum_cmd_o[k] = '0;
            if (state_q == SET_POP_NUM) begin
                ifmap_cmd_o[k].need_pop = 1'b1;
                ifmap_cmd_o[k].count    = ifmap_count(layer_type_i, k);
                ipsum_cmd_o[k].need_pop = 1'b1;
                ipsum_cmd_o[k].count    = l2c_pkg::cnt_t'(1);  // One psum per row
            end
        end
    end

    assign preheat_done_o   = (state_q == DONE);
    assign opsum_push_one_o = (state_q == DONE);   // Kick the opsum path once

endmodule

`default_nettype wire

//--- verilog/pop_fifo.sv
/*
 * Lane FIFO
 * Refills itself from its own GLB region and pops a commanded
 * number of entries toward one PE row, one per cycle
 */
`timescale 1ns/100ps
`default_nettype none

module pop_fifo #(
    parameter type                payload_t = l2c_pkg::ifmap_t,
    parameter l2c_pkg::glb_addr_t LANE_BASE = '0
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire l2c_pkg::pop_cmd_t  cmd_i,
    output logic                    done_o,
    output l2c_pkg::glb_req_t       req_o,
    input  wire logic               rsp_valid_i,
    input  wire l2c_pkg::glb_data_t rsp_data_i,
    output logic                    pe_valid_o,
    output payload_t                pe_data_o
);

    localparam int PW = $bits(payload_t);

    payload_t                    mem [l2c_pkg::FIFO_DEPTH];
    logic [l2c_pkg::FIFO_AW-1:0] wr_ptr;
    logic [l2c_pkg::FIFO_AW-1:0] rd_ptr;
    logic [l2c_pkg::FIFO_AW:0]   count;         // Stored entries
    logic [l2c_pkg::FETCH_W-1:0] fetch_ptr;     // Next word within the region
    l2c_pkg::cnt_t               remain;        // Pops still owed to the PE row
    logic                        room;
    logic                        pop;

    // ========================================
    // Refill request
    // ========================================
    // A read returning this cycle already owns a slot
    assign room = rsp_valid_i ? (count < l2c_pkg::FIFO_DEPTH - 1)
                              : (count < l2c_pkg::FIFO_DEPTH);

    assign req_o.req  = room && (fetch_ptr < l2c_pkg::REGION_WORDS);
    assign req_o.addr = LANE_BASE + l2c_pkg::glb_addr_t'(fetch_ptr);

    // ========================================
    // Pop toward the PE row
    // ========================================
    assign pop    = (remain != '0) && (count != '0);
    assign done_o = (remain == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            fetch_ptr <= '0;
        end else begin
            if (rsp_valid_i) begin
                wr_ptr    <= wr_ptr + 1'b1;
                fetch_ptr <= fetch_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({rsp_valid_i, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remain     <= '0;
            pe_valid_o <= 1'b0;
        end else begin
            pe_valid_o <= pop;
            if (cmd_i.need_pop) begin
                remain <= cmd_i.count;          // New tile overrides the old count
            end else if (pop) begin
                remain <= remain - 1'b1;
            end
        end
    end

    // Storage and output data
    always_ff @(posedge clk) begin
        if (rsp_valid_i) begin
            mem[wr_ptr] <= payload_t'(rsp_data_i[PW-1:0]);
        end
        if (pop) begin
            pe_data_o <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/glb_arbiter.sv
/*
 * GLB read port arbiter
 * Round-robin grant among the lane FIFOs, one read per cycle,
 * with the read word routed back to the previous winner
 */
`timescale 1ns/100ps
`default_nettype none

module glb_arbiter (
    input  wire logic                                        clk,
    input  wire logic                                        rst_n,
    input  wire l2c_pkg::glb_req_t [l2c_pkg::NUM_REQ-1:0]    req_i,
    output logic                                             rd_en_o,
    output l2c_pkg::glb_addr_t                               rd_addr_o,
    input  wire l2c_pkg::glb_data_t                          rd_data_i,
    output logic [l2c_pkg::NUM_REQ-1:0]                      rsp_valid_o,
    output l2c_pkg::glb_data_t                               rsp_data_o
);

    l2c_pkg::req_idx_t            rr_ptr;   // First index searched
    l2c_pkg::req_idx_t            win;
    l2c_pkg::req_idx_t            win_q;    // Winner of the read in flight
    logic                         pend_q;
    logic                         grant;
    logic [l2c_pkg::NUM_REQ-1:0]  elig;

    // A requester with a read in flight may not be granted again
    always_comb begin
        for (int r = 0; r < l2c_pkg::NUM_REQ; r++) begin
            elig[r] = req_i[r].req && !(pend_q && (win_q == l2c_pkg::req_idx_t'(r)));
        end
    end

    always_comb begin
        l2c_pkg::req_idx_t idx;
        grant = 1'b0;
        win   = rr_ptr;
        for (int i = 0; i < l2c_pkg::NUM_REQ; i++) begin
            idx = l2c_pkg::req_idx_t'((int'(rr_ptr) + i) % l2c_pkg::NUM_REQ);
            if (!grant && elig[idx]) begin
                grant = 1'b1;
                win   = idx;
            end
        end
    end

    assign rd_en_o   = grant;
    assign rd_addr_o = req_i[win].addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= '0;
            win_q  <= '0;
            pend_q <= 1'b0;
        end else begin
            pend_q <= grant;
            if (grant) begin
                win_q  <= win;
                rr_ptr <= l2c_pkg::req_idx_t'((int'(win) + 1) % l2c_pkg::NUM_REQ);
            end
        end
    end

    // Response one cycle after the grant
    always_comb begin
        rsp_valid_o = '0;
        if (pend_q) begin
            rsp_valid_o[win_q] = 1'b1;
        end
    end

    assign rsp_data_o = rd_data_i;

endmodule

`default_nettype wire

//--- verilog/glb_bank.sv
/*
 * Global buffer
 * Single write port for loading, one registered read port
 */
`timescale 1ns/100ps
`default_nettype none

module glb_bank (
    input  wire logic               clk,
    input  wire logic               wr_en_i,
    input  wire l2c_pkg::glb_addr_t wr_addr_i,
    input  wire l2c_pkg::glb_data_t wr_data_i,
    input  wire logic               rd_en_i,
    input  wire l2c_pkg::glb_addr_t rd_addr_i,
    output l2c_pkg::glb_data_t      rd_data_o
);

    l2c_pkg::glb_data_t mem [l2c_pkg::GLB_DEPTH];

    // ========================================
    // Write port
    // ========================================
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // ========================================
    // Read port
    // ========================================
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];   // Holds last word when idle
        end
    end

endmodule

`default_nettype wire

//--- verilog/l2c_preheat_top.sv
/*
 * L2C preheat stage
 * Controller, ifmap and ipsum lane FIFOs, GLB arbiter and GLB
 */
`timescale 1ns/100ps
`default_nettype none

module l2c_preheat_top (
    input  wire logic                                        clk,
    input  wire logic                                        rst_n,
    input  wire logic                                        start_preheat_i,
    input  wire l2c_pkg::layer_type_e                        layer_type_i,
    input  wire logic                                        glb_wr_en_i,
    input  wire l2c_pkg::glb_addr_t                          glb_wr_addr_i,
    input  wire l2c_pkg::glb_data_t                          glb_wr_data_i,
    output logic [l2c_pkg::NUM_LANES-1:0]                    ifmap_valid_o,
    output l2c_pkg::ifmap_t [l2c_pkg::NUM_LANES-1:0]         ifmap_data_o,
    output logic [l2c_pkg::NUM_LANES-1:0]                    ipsum_valid_o,
    output l2c_pkg::ipsum_t [l2c_pkg::NUM_LANES-1:0]         ipsum_data_o,
    output logic                                             opsum_push_one_o,
    output logic                                             preheat_done_o
);

    l2c_pkg::pop_cmd_t [l2c_pkg::NUM_LANES-1:0] ifmap_cmd;
    l2c_pkg::pop_cmd_t [l2c_pkg::NUM_LANES-1:0] ipsum_cmd;
    logic [l2c_pkg::NUM_LANES-1:0]              ifmap_done;
    logic [l2c_pkg::NUM_LANES-1:0]              ipsum_done;
    l2c_pkg::glb_req_t [l2c_pkg::NUM_REQ-1:0]   glb_req;    // Ifmap lanes low, ipsum high
    logic [l2c_pkg::NUM_REQ-1:0]                rsp_valid;
    l2c_pkg::glb_data_t                         rsp_data;
    logic                                       rd_en;
    l2c_pkg::glb_addr_t                         rd_addr;
    l2c_pkg::glb_data_t                         rd_data;

    l2c_preheat_ctrl l2c_preheat_ctrl_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .start_preheat_i  (start_preheat_i),
        .layer_type_i     (layer_type_i),
        .ifmap_done_i     (ifmap_done),
        .ipsum_done_i     (ipsum_done),
        .ifmap_cmd_o      (ifmap_cmd),
        .ipsum_cmd_o      (ipsum_cmd),
        .opsum_push_one_o (opsum_push_one_o),
        .preheat_done_o   (preheat_done_o)
    );

    // ========================================
    // Lane FIFOs
    // ========================================
    for (genvar k = 0; k < l2c_pkg::NUM_LANES; k++) begin : g_ifmap
        pop_fifo #(
            .payload_t (l2c_pkg::ifmap_t),
            .LANE_BASE (l2c_pkg::glb_addr_t'(k * l2c_pkg::REGION_WORDS))
        ) ifmap_fifo_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .cmd_i       (ifmap_cmd[k]),
            .done_o      (ifmap_done[k]),
            .req_o       (glb_req[k]),
            .rsp_valid_i (rsp_valid[k]),
            .rsp_data_i  (rsp_data),
            .pe_valid_o  (ifmap_valid_o[k]),
            .pe_data_o   (ifmap_data_o[k])
        );
    end

    for (genvar k = 0; k < l2c_pkg::NUM_LANES; k++) begin : g_ipsum
        pop_fifo #(
            .payload_t (l2c_pkg::ipsum_t),
            .LANE_BASE (l2c_pkg::glb_addr_t'((k + l2c_pkg::NUM_LANES) * l2c_pkg::REGION_WORDS))
        ) ipsum_fifo_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .cmd_i       (ipsum_cmd[k]),
            .done_o      (ipsum_done[k]),
            .req_o       (glb_req[k + l2c_pkg::NUM_LANES]),
            .rsp_valid_i (rsp_valid[k + l2c_pkg::NUM_LANES]),
            .rsp_data_i  (rsp_data),
            .pe_valid_o  (ipsum_valid_o[k]),
            .pe_data_o   (ipsum_data_o[k])
        );
    end

    // ========================================
    // GLB and its read port arbiter
    // ========================================
    glb_arbiter glb_arbiter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (glb_req),
        .rd_en_o     (rd_en),
        .rd_addr_o   (rd_addr),
        .rd_data_i   (rd_data),
        .rsp_valid_o (rsp_valid),
        .rsp_data_o  (rsp_data)
    );

    glb_bank glb_bank_i (
        .clk       (clk),
        .wr_en_i   (glb_wr_en_i),
        .wr_addr_i (glb_wr_addr_i),
        .wr_data_i (glb_wr_data_i),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

endmodule

`default_nettype wire

//--- verif/l2c_preheat_tb.sv
/*
 * L2C preheat testbench
 * Runs each layer type through the preheat stage and checks lane
 * counts, lane data order and the done and opsum pulses
 */
`timescale 1ns/100ps
`default_nettype none

module l2c_preheat_tb;

    localparam int NUM_TESTS      = 4;
    localparam int TEST_CYCLES    = 60;
    localparam int TIMEOUT_CYCLES = l2c_pkg::GLB_DEPTH + 32 + NUM_TESTS * TEST_CYCLES;

    logic                                            clk;
    logic                                            rst_n;
    logic                                            start_preheat_i;
    l2c_pkg::layer_type_e                            layer_type_i;
    logic                                            glb_wr_en_i;
    l2c_pkg::glb_addr_t                              glb_wr_addr_i;
    l2c_pkg::glb_data_t                              glb_wr_data_i;
    logic [l2c_pkg::NUM_LANES-1:0]                   ifmap_valid_o;
    l2c_pkg::ifmap_t [l2c_pkg::NUM_LANES-1:0]        ifmap_data_o;
    logic [l2c_pkg::NUM_LANES-1:0]                   ipsum_valid_o;
    l2c_pkg::ipsum_t [l2c_pkg::NUM_LANES-1:0]        ipsum_data_o;
    logic                                            opsum_push_one_o;
    logic                                            preheat_done_o;

    // ========================================
    // Test table
    // ========================================
    string                test_name  [NUM_TESTS] = '{"pointwise", "depthwise", "standard",
                                                     "linear"};
    l2c_pkg::layer_type_e test_layer [NUM_TESTS] = '{l2c_pkg::POINTWISE, l2c_pkg::DEPTHWISE,
                                                     l2c_pkg::STANDARD, l2c_pkg::LINEAR};
    l2c_pkg::cnt_t test_ifmap_cnt [NUM_TESTS][l2c_pkg::NUM_LANES] = '{
        '{4'd1, 4'd1, 4'd1, 4'd1},
        '{4'd3, 4'd3, 4'd3, 4'd6},      // Last row gets the double window
        '{4'd3, 4'd3, 4'd3, 4'd3},
        '{4'd1, 4'd1, 4'd1, 4'd1}
    };

    // Model of the GLB contents and of how far each lane has read
    l2c_pkg::glb_data_t glb_model [l2c_pkg::GLB_DEPTH];
    int                 ifmap_ptr [l2c_pkg::NUM_LANES];
    int                 ipsum_ptr [l2c_pkg::NUM_LANES];
    logic [31:0]        lcg_state;
    int                 cycle_count;

    l2c_preheat_top l2c_preheat_top_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .start_preheat_i  (start_preheat_i),
        .layer_type_i     (layer_type_i),
        .glb_wr_en_i      (glb_wr_en_i),
        .glb_wr_addr_i    (glb_wr_addr_i),
        .glb_wr_data_i    (glb_wr_data_i),
        .ifmap_valid_o    (ifmap_valid_o),
        .ifmap_data_o     (ifmap_data_o),
        .ipsum_valid_o    (ipsum_valid_o),
        .ipsum_data_o     (ipsum_data_o),
        .opsum_push_one_o (opsum_push_one_o),
        .preheat_done_o   (preheat_done_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            fail_run($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        lcg_next = state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic fail_run(input string reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "%s", reason);
    endtask

    // ========================================
    // Compare tasks
    // ========================================
    task automatic check_ifmap(input string name, input l2c_pkg::ifmap_t exp,
                               input l2c_pkg::ifmap_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            fail_run("ifmap data mismatch");
        end
    endtask

    task automatic check_ipsum(input string name, input l2c_pkg::ipsum_t exp,
                               input l2c_pkg::ipsum_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            fail_run("ipsum data mismatch");
        end
    endtask

    task automatic check_count(input string name, input l2c_pkg::cnt_t exp,
                               input l2c_pkg::cnt_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            fail_run("pop count mismatch");
        end
    endtask

    task automatic check_pulse(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            fail_run("control pulse mismatch");
        end
    endtask

    // Nothing may leave the stage while the controller is idle
    task automatic idle_check(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_pulse({name, " pe valid"}, 1'b0, |{ifmap_valid_o, ipsum_valid_o});
            check_pulse({name, " preheat done"}, 1'b0, preheat_done_o);
            check_pulse({name, " opsum push"}, 1'b0, opsum_push_one_o);
        end
    endtask

    task automatic run_test(input int t);
        l2c_pkg::cnt_t   ifmap_seen [l2c_pkg::NUM_LANES];
        l2c_pkg::cnt_t   ipsum_seen [l2c_pkg::NUM_LANES];
        l2c_pkg::ifmap_t exp_ifmap;
        l2c_pkg::ipsum_t exp_ipsum;
        int              base;
        bit              finished;
        for (int k = 0; k < l2c_pkg::NUM_LANES; k++) begin
            ifmap_seen[k] = '0;
            ipsum_seen[k] = '0;
        end
        @(posedge clk);
        start_preheat_i <= 1'b1;
        layer_type_i    <= test_layer[t];
        @(posedge clk);
        start_preheat_i <= 1'b0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            if (preheat_done_o) begin
                check_pulse({test_name[t], " valid with done"}, 1'b0,
                            |{ifmap_valid_o, ipsum_valid_o});
                check_pulse({test_name[t], " opsum push"}, 1'b1, opsum_push_one_o);
                finished = 1'b1;
            end else begin
                check_pulse({test_name[t], " opsum push before done"}, 1'b0,
                            opsum_push_one_o);
            end
            for (int k = 0; k < l2c_pkg::NUM_LANES; k++) begin
                if (ifmap_valid_o[k]) begin
                    base = k * l2c_pkg::REGION_WORDS;
                    exp_ifmap.act = glb_model[base + ifmap_ptr[k] % l2c_pkg::REGION_WORDS][7:0];
                    check_ifmap($sformatf("%s ifmap lane %0d", test_name[t], k),
                                exp_ifmap, ifmap_data_o[k]);
                    ifmap_ptr[k]++;
                    ifmap_seen[k] = ifmap_seen[k] + 1'b1;
                end
                if (ipsum_valid_o[k]) begin
                    base = (k + l2c_pkg::NUM_LANES) * l2c_pkg::REGION_WORDS;
                    exp_ipsum.psum = glb_model[base + ipsum_ptr[k] % l2c_pkg::REGION_WORDS];
                    check_ipsum($sformatf("%s ipsum lane %0d", test_name[t], k),
                                exp_ipsum, ipsum_data_o[k]);
                    ipsum_ptr[k]++;
                    ipsum_seen[k] = ipsum_seen[k] + 1'b1;
                end
            end
        end
        for (int k = 0; k < l2c_pkg::NUM_LANES; k++) begin
            check_count($sformatf("%s ifmap count lane %0d", test_name[t], k),
                        test_ifmap_cnt[t][k], ifmap_seen[k]);
            check_count($sformatf("%s ipsum count lane %0d", test_name[t], k),
                        4'd1, ipsum_seen[k]);
        end
        idle_check({test_name[t], " after done"}, 4);   // Done lasts one cycle
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        start_preheat_i = 1'b0;
        layer_type_i    = l2c_pkg::POINTWISE;
        glb_wr_en_i     = 1'b0;
        glb_wr_addr_i   = '0;
        glb_wr_data_i   = '0;
        cycle_count     = 0;
        lcg_state       = 32'd17638;
        for (int k = 0; k < l2c_pkg::NUM_LANES; k++) begin
            ifmap_ptr[k] = 0;
            ipsum_ptr[k] = 0;
        end

        // FIFOs prefetch as soon as reset drops, so load the GLB first
        for (int a = 0; a < l2c_pkg::GLB_DEPTH; a++) begin
            lcg_state    = lcg_next(lcg_state);
            glb_model[a] = lcg_state[31:16];
            @(posedge clk);
            glb_wr_en_i   <= 1'b1;
            glb_wr_addr_i <= l2c_pkg::glb_addr_t'(a);
            glb_wr_data_i <= lcg_state[31:16];
        end
        @(posedge clk);
        glb_wr_en_i <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        idle_check("after reset", 12);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
verilog/l2c_pkg.sv
verilog/l2c_preheat_ctrl.sv
verilog/pop_fifo.sv
verilog/glb_arbiter.sv
verilog/glb_bank.sv
verilog/l2c_preheat_top.sv
verif/l2c_preheat_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the preheat testbench with Verilator, run it and scan the log.
# Exit status is nonzero unless the log holds the pass line.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module l2c_preheat_tb \
    -f sources.f -o sim_l2c_preheat > build.log 2>&1 \
    || { cat build.log; exit 1; }

./obj_dir/sim_l2c_preheat > sim.log 2>&1 ; cat sim.log

grep -qx "ALL TESTS PASSED" sim.log && exit 0 || exit 1
